// ==== verif/nts_tx_tests.txt ====
# P words last_bytes family(4 or 6) seed dropped(0 sent, 1 dropped by overrun)
# C words seed, writes the words then clears the packet
P 6 5 4 1 0
P 3 8 4 2 0
P 9 1 6 3 0
P 2 4 6 4 0
P 17 7 4 5 0
P 1 3 4 6 0
P 64 8 6 7 0
P 64 2 4 8 0
P 70 4 4 9 1
P 5 6 6 10 0
P 65 8 6 11 1
P 1 8 6 12 0
C 7 13
P 4 2 4 14 0
C 1 15
P 12 6 6 16 0
P 64 8 4 17 0
P 8 8 4 18 0
P 30 1 6 19 0
P 2 7 4 20 0

// ==== src.f ====
hdl/nts_tx_pkg.sv
hdl/nts_tx_mem.sv
hdl/nts_tx_writer.sv
hdl/nts_tx_buffer.sv
hdl/nts_tx_dispatch.sv
hdl/nts_tx_top.sv
verif/nts_tx_checker.sv
verif/nts_tx_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module nts_tx_tb -f src.f -o nts_tx_sim &&
./obj_dir/nts_tx_sim | tee /dev/stderr | grep -qx "TEST OK" ||
{ echo "simulation did not pass"; exit 1; }

// ==== verif/nts_tx_tb.sv ====
`timescale 1ns/1ps

module nts_tx_tb;

  // One line of the tests file
  typedef struct packed {
    logic       clear;
    logic [7:0] words;
    logic [3:0] last_bytes;
    logic       ipv6;
    logic       drop;
    int         seed;
  } test_t;

  localparam int SEED_BASE = 57629;

  logic        clk;
  logic        areset;
  logic        parser_clear;
  logic        parser_w_en;
  logic [63:0] parser_w_data;
  logic        parser_ipv4_done;
  logic        parser_ipv6_done;
  logic [3:0]  parser_last_bytes;
  logic        parser_full;
  logic        parser_empty;
  logic        drop;
  logic        tx_valid;
  logic [63:0] tx_data;
  logic        tx_last;
  logic [3:0]  tx_bytes;
  logic        tx_ipv6;

  test_t tests[$];
  int    cycles;
  int    cycle_limit;
  int    ctl_errors;
  int    chk_errors;
  int    missing;
  int    sent_dones;

  nts_tx_top nts_tx_top_inst (
    .i_clk               (clk),
    .i_areset            (areset),
    .i_parser_clear      (parser_clear),
    .i_parser_w_en       (parser_w_en),
    .i_parser_w_data     (parser_w_data),
    .i_parser_ipv4_done  (parser_ipv4_done),
    .i_parser_ipv6_done  (parser_ipv6_done),
    .i_parser_last_bytes (parser_last_bytes),
    .o_parser_full       (parser_full),
    .o_parser_empty      (parser_empty),
    .o_drop              (drop),
    .o_tx_valid          (tx_valid),
    .o_tx_data           (tx_data),
    .o_tx_last           (tx_last),
    .o_tx_bytes          (tx_bytes),
    .o_tx_ipv6           (tx_ipv6)
  );

  nts_tx_checker u_checker (
    .i_clk        (clk),
    .i_areset     (areset),
    .i_parser_full(parser_full),
    .i_drop       (drop),
    .i_tx_valid   (tx_valid),
    .i_tx_data    (tx_data),
    .i_tx_last    (tx_last),
    .i_tx_bytes   (tx_bytes),
    .i_tx_ipv6    (tx_ipv6),
    .i_sent_dones (sent_dones),
    .o_errors     (chk_errors),
    .o_missing    (missing)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  // Run limit from the total word count of the tests file
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, %0d expected words or drops never seen",
               cycles, missing);
      $display("TEST FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Tests file
  // --------------------------------------------------------------------------

  task automatic read_tests(output bit ok);
    int    fd;
    int    n;
    string line;
    test_t t;
    int    words;
    int    last_bytes;
    int    family;
    int    seed_ofs;
    int    dropped;
    ok = 1'b0;
    fd = $fopen("verif/nts_tx_tests.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      cycle_limit = 200;
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        t = '0;
        if (n > 0 && line.getc(0) == "P") begin
          n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d %d",
                      words, last_bytes, family, seed_ofs, dropped);
          t.words      = 8'(words);
          t.last_bytes = 4'(last_bytes);
          t.ipv6       = (family == 6);
          t.drop       = (dropped != 0);
          t.seed       = seed_ofs;
          tests.push_back(t);
          cycle_limit += 4 * words;
        end else if (n > 0 && line.getc(0) == "C") begin
          n = $sscanf(line.substr(1, line.len() - 1), "%d %d", words, seed_ofs);
          t.clear = 1'b1;
          t.words = 8'(words);
          t.seed  = seed_ofs;
          tests.push_back(t);
          cycle_limit += 4 * words;
        end
      end
      $fclose(fd);
    end
  endtask

  // --------------------------------------------------------------------------
  // Parser side
  // --------------------------------------------------------------------------

  // Writes the words of one line, ends with done or clear
  task automatic drive_test(input test_t t);
    int          s;
    logic [63:0] data;
    logic        last;
    s = SEED_BASE + t.seed;
    if (t.drop) begin
      u_checker.note_drop();
    end
    for (int i = 0; i < int'(t.words); i++) begin
      data = {$random(s), $random(s)};
      last = (i == int'(t.words) - 1);
      @(posedge clk);
      parser_w_en   <= 1'b1;
      parser_w_data <= data;
      if (last && !t.clear) begin
        parser_last_bytes <= t.last_bytes;
        if (t.ipv6) begin
          parser_ipv6_done <= 1'b1;
        end else begin
          parser_ipv4_done <= 1'b1;
        end
        if (!t.drop) begin
          sent_dones++;
        end
      end
      if (!t.clear && !t.drop) begin
        u_checker.queue_word(data, last, t.last_bytes, t.ipv6);
      end
    end
    @(posedge clk);
    parser_w_en      <= 1'b0;
    parser_ipv4_done <= 1'b0;
    parser_ipv6_done <= 1'b0;
    parser_clear     <= t.clear;
    @(posedge clk);
    parser_clear <= 1'b0;
    // Writer and buffer pipeline settles
    @(posedge clk);
  endtask

  // Next packet only into a free bank, which must read empty
  task automatic wait_for_bank();
    @(negedge clk);
    while (parser_full) begin
      @(negedge clk);
    end
    if (!parser_empty) begin
      ctl_errors++;
      $display("ERR %0t: parser bank free but o_parser_empty low", $time);
    end
  endtask

  initial begin
    bit ok;
    clk               = 1'b0;
    areset            = 1'b1;
    parser_clear      = 1'b0;
    parser_w_en       = 1'b0;
    parser_w_data     = '0;
    parser_ipv4_done  = 1'b0;
    parser_ipv6_done  = 1'b0;
    parser_last_bytes = '0;
    cycles            = 0;
    cycle_limit       = 0;
    ctl_errors        = 0;
    sent_dones        = 0;
    read_tests(ok);
    if (!ok) begin
      $display("Cannot open verif/nts_tx_tests.txt for reading");
      $display("TEST FAILED");
      $finish;
    end else begin
      repeat (5) @(posedge clk);
      areset <= 1'b0;
      wait_for_bank();
      foreach (tests[i]) begin
        drive_test(tests[i]);
        wait_for_bank();
      end
      // All expected words and drops seen, then catch stray output
      while (missing != 0) begin
        @(negedge clk);
      end
      repeat (20) @(posedge clk);
      $display("Errors: checker %0d, testbench %0d", chk_errors, ctl_errors);
      if (chk_errors + ctl_errors == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

// ==== verif/nts_tx_checker.sv ====
`timescale 1ns/1ps

module nts_tx_checker (
  input  logic        i_clk,
  input  logic        i_areset,
  input  logic        i_parser_full,
  input  logic        i_drop,
  input  logic        i_tx_valid,
  input  logic [63:0] i_tx_data,
  input  logic        i_tx_last,
  input  logic [3:0]  i_tx_bytes,
  input  logic        i_tx_ipv6,
  input  int          i_sent_dones,
  output int          o_errors,
  output int          o_missing
);

  // Expected output word
  typedef struct packed {
    logic [63:0] data;
    logic        last;
    logic [3:0]  bytes;
    logic        ipv6;
  } exp_word_t;

  exp_word_t exp_q[$];
  int        drops_due;
  int        packets_out;
  // Done count delayed until the buffer has taken it
  int        dones_d1;
  int        dones_d2;

  task automatic queue_word(input logic [63:0] data, input logic last,
                            input logic [3:0] bytes, input logic ipv6);
    exp_word_t w;
    w.data  = data;
    w.last  = last;
    w.bytes = bytes;
    w.ipv6  = ipv6;
    exp_q.push_back(w);
  endtask

  task automatic note_drop();
    drops_due++;
  endtask

  initial begin
    o_errors    = 0;
    o_missing   = 0;
    drops_due   = 0;
    packets_out = 0;
    dones_d1    = 0;
    dones_d2    = 0;
  end

  // Outputs sampled mid-cycle
  always @(negedge i_clk) begin : watch
    exp_word_t w;
    if (!i_areset) begin
      if (i_tx_valid) begin
        if (exp_q.size() == 0) begin
          o_errors++;
          $display("ERR %0t: unexpected word %h", $time, i_tx_data);
        end else begin
          w = exp_q.pop_front();
          if (i_tx_data !== w.data || i_tx_last !== w.last || i_tx_ipv6 !== w.ipv6) begin
            o_errors++;
            $display("ERR %0t: got %h last %b ipv6 %b, expected %h last %b ipv6 %b",
                     $time, i_tx_data, i_tx_last, i_tx_ipv6, w.data, w.last, w.ipv6);
          end
          // Byte count only valid with the final word
          if (w.last && i_tx_bytes !== w.bytes) begin
            o_errors++;
            $display("ERR %0t: last word bytes %0d, expected %0d", $time, i_tx_bytes, w.bytes);
          end
        end
        if (i_tx_last) begin
          packets_out++;
        end
      end else if (i_tx_last) begin
        o_errors++;
        $display("ERR %0t: o_tx_last without o_tx_valid", $time);
      end
      if (i_drop) begin
        if (drops_due == 0) begin
          o_errors++;
          $display("ERR %0t: unexpected drop pulse", $time);
        end else begin
          drops_due--;
        end
      end
      // Two unsent packets mean both banks are taken
      if (dones_d2 - packets_out >= 2 && !i_parser_full) begin
        o_errors++;
        $display("ERR %0t: o_parser_full low with both banks holding packets", $time);
      end
      dones_d2 = dones_d1;
      dones_d1 = i_sent_dones;
    end
    o_missing = exp_q.size() + drops_due;
  end

endmodule

// ==== hdl/nts_tx_top.sv ====
`timescale 1ns/1ps

module nts_tx_top (
  input  logic        i_clk,
  input  logic        i_areset,
  input  logic        i_parser_clear,
  input  logic        i_parser_w_en,
  input  logic [63:0] i_parser_w_data,
  input  logic        i_parser_ipv4_done,
  input  logic        i_parser_ipv6_done,
  input  logic [3:0]  i_parser_last_bytes,
  output logic        o_parser_full,
  output logic        o_parser_empty,
  output logic        o_drop,
  output logic        o_tx_valid,
  output logic [63:0] o_tx_data,
  output logic        o_tx_last,
  output logic [3:0]  o_tx_bytes,
  output logic        o_tx_ipv6
);
  import nts_tx_pkg::*;

  // Writer to buffer
  nts_tx_wr_t   wr;
  nts_tx_desc_t desc;
  logic         clear;

  // Buffer to dispatcher
  logic         fifo_ready;
  nts_tx_desc_t fifo_desc;
  logic [63:0]  rd_data;
  logic         rd_en;
  nts_tx_addr_t rd_addr;
  logic         packet_read;

  nts_tx_writer u_writer (
    .i_clk               (i_clk),
    .i_areset            (i_areset),
    .i_parser_clear      (i_parser_clear),
    .i_parser_w_en       (i_parser_w_en),
    .i_parser_w_data     (i_parser_w_data),
    .i_parser_ipv4_done  (i_parser_ipv4_done),
    .i_parser_ipv6_done  (i_parser_ipv6_done),
    .i_parser_last_bytes (i_parser_last_bytes),
    .o_wr                (wr),
    .o_desc              (desc),
    .o_clear             (clear)
  );

  nts_tx_buffer u_buffer (
    .i_clk          (i_clk),
    .i_areset       (i_areset),
    .i_wr           (wr),
    .i_desc         (desc),
    .i_clear        (clear),
    .i_rd_en        (rd_en),
    .i_rd_addr      (rd_addr),
    .i_packet_read  (packet_read),
    .o_fifo_ready   (fifo_ready),
    .o_fifo_desc    (fifo_desc),
    .o_rd_data      (rd_data),
    .o_parser_full  (o_parser_full),
    .o_parser_empty (o_parser_empty),
    .o_drop         (o_drop)
  );

  nts_tx_dispatch u_dispatch (
    .i_clk         (i_clk),
    .i_areset      (i_areset),
    .i_fifo_ready  (fifo_ready),
    .i_fifo_desc   (fifo_desc),
    .i_rd_data     (rd_data),
    .o_rd_en       (rd_en),
    .o_rd_addr     (rd_addr),
    .o_packet_read (packet_read),
    .o_tx_valid    (o_tx_valid),
    .o_tx_data     (o_tx_data),
    .o_tx_last     (o_tx_last),
    .o_tx_bytes    (o_tx_bytes),
    .o_tx_ipv6     (o_tx_ipv6)
  );

endmodule

// ==== hdl/nts_tx_dispatch.sv ====
`timescale 1ns/1ps

module nts_tx_dispatch (
  input  logic                     i_clk,
  input  logic                     i_areset,
  input  logic                     i_fifo_ready,
  input  nts_tx_pkg::nts_tx_desc_t i_fifo_desc,
  input  logic [63:0]              i_rd_data,
  output logic                     o_rd_en,
  output nts_tx_pkg::nts_tx_addr_t o_rd_addr,
  output logic                     o_packet_read,
  output logic                     o_tx_valid,
  output logic [63:0]              o_tx_data,
  output logic                     o_tx_last,
  output logic [3:0]               o_tx_bytes,
  output logic                     o_tx_ipv6
);
  import nts_tx_pkg::*;

  nts_tx_len_t  len_m1;
  logic         start;
  logic         busy_q;
  nts_tx_addr_t addr_q;
  nts_tx_addr_t last_addr_q;
  logic [3:0]   bytes_q;
  logic         ipv6_q;
  logic         valid_q;
  logic         last_q;
  logic [3:0]   tx_bytes_q;
  logic         tx_ipv6_q;

  // Length minus one splits into last word index and last byte offset
  // Also restores a full bank whose length wrapped to zero
  assign len_m1 = i_fifo_desc.len - 1'b1;
  assign start  = i_fifo_ready && i_fifo_desc.done && !busy_q;

  // One read per cycle while busy
  assign o_rd_en       = busy_q;
  assign o_rd_addr     = addr_q;
  // Bank released with the last read
  assign o_packet_read = busy_q && (addr_q == last_addr_q);

  // -------------------------------------------------------------------------
  // Read sequencer and output alignment
  // -------------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      busy_q     <= 1'b0;
      addr_q     <= '0;
      valid_q    <= 1'b0;
      last_q     <= 1'b0;
      tx_bytes_q <= '0;
      tx_ipv6_q  <= 1'b0;
    end else begin
      // Memory data follows the read by one cycle
      valid_q    <= busy_q;
      last_q     <= o_packet_read;
      tx_bytes_q <= o_packet_read ? bytes_q : 4'd0;
      tx_ipv6_q  <= busy_q && ipv6_q;
      if (start) begin
        busy_q <= 1'b1;
        addr_q <= '0;
      end else if (o_packet_read) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  // Descriptor fields held for the packet
  always_ff @(posedge i_clk) begin
    if (start) begin
      last_addr_q <= len_m1[NTS_TX_LEN_WIDTH-1:3];
      bytes_q     <= {1'b0, len_m1[2:0]} + 4'd1;
      ipv6_q      <= i_fifo_desc.ipv6;
    end
  end

  assign o_tx_valid = valid_q;
  assign o_tx_data  = i_rd_data;
  assign o_tx_last  = last_q;
  assign o_tx_bytes = tx_bytes_q;
  assign o_tx_ipv6  = tx_ipv6_q;

endmodule

// ==== hdl/nts_tx_buffer.sv ====
`timescale 1ns/1ps

module nts_tx_buffer (
  input  logic                     i_clk,
  input  logic                     i_areset,
  input  nts_tx_pkg::nts_tx_wr_t   i_wr,
  input  nts_tx_pkg::nts_tx_desc_t i_desc,
  input  logic                     i_clear,
  input  logic                     i_rd_en,
  input  nts_tx_pkg::nts_tx_addr_t i_rd_addr,
  input  logic                     i_packet_read,
  output logic                     o_fifo_ready,
  output nts_tx_pkg::nts_tx_desc_t o_fifo_desc,
  output logic [63:0]              o_rd_data,
  output logic                     o_parser_full,
  output logic                     o_parser_empty,
  output logic                     o_drop
);
  import nts_tx_pkg::*;

  // -------------------------------------------------------------------------
  // Bank registers
  // -------------------------------------------------------------------------

  logic                       cur_q;
  nts_tx_state_e              state_q [2];
  logic [NTS_TX_ADDR_WIDTH:0] cnt_q   [2];
  nts_tx_desc_t               desc_q  [2];
  logic                       drop_q;

  logic        parser;
  logic        drain;
  logic        cnt_full;
  logic        parser_open;
  logic        live;
  logic        wr_take;
  logic        overrun;
  logic        done_ok;
  logic        mem_we  [2];
  logic        mem_re  [2];
  logic [63:0] mem_rd  [2];
  logic        mem_err [2];

  // Parser fills cur_q, dispatcher drains the other
  assign parser = cur_q;
  assign drain  = ~cur_q;

  // Word count reached bank capacity
  assign cnt_full    = cnt_q[parser][NTS_TX_ADDR_WIDTH];
  assign parser_open = (state_q[parser] == BANK_EMPTY) || (state_q[parser] == BANK_HAS_DATA);
  assign live        = !i_clear && !mem_err[parser];

  // Write lands in memory
  assign wr_take = i_wr.w_en && live && parser_open && !cnt_full;
  // Write beyond the last word
  assign overrun = i_wr.w_en && live && (state_q[parser] == BANK_HAS_DATA) && cnt_full;
  // Completed packet with at least one word
  assign done_ok = i_desc.done && live && parser_open && !overrun &&
                   ((cnt_q[parser] != '0) || wr_take);

  // -------------------------------------------------------------------------
  // Memories
  // -------------------------------------------------------------------------

  for (genvar b = 0; b < 2; b++) begin : g_bank
    assign mem_we[b] = wr_take && (parser == 1'(b));
    assign mem_re[b] = i_rd_en && (drain == 1'(b));

    nts_tx_mem u_mem (
      .i_clk     (i_clk),
      .i_areset  (i_areset),
      .i_wr_en   (mem_we[b]),
      .i_wr_addr (cnt_q[parser][NTS_TX_ADDR_WIDTH-1:0]),
      .i_wr_data (i_wr.w_data),
      .i_rd_en   (mem_re[b]),
      .i_rd_addr (i_rd_addr),
      .o_rd_data (mem_rd[b]),
      .o_error   (mem_err[b])
    );
  end

  // -------------------------------------------------------------------------
  // Bank state machines
  // -------------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      cur_q  <= 1'b0;
      drop_q <= 1'b0;
      for (int b = 0; b < 2; b++) begin
        state_q[b] <= BANK_EMPTY;
        cnt_q[b]   <= '0;
      end
    end else begin
      drop_q <= 1'b0;

      // Parser side
      if (mem_err[parser]) begin
        state_q[parser] <= BANK_ERROR;
      end else if (i_clear) begin
        state_q[parser] <= BANK_EMPTY;
        cnt_q[parser]   <= '0;
      end else begin
        case (state_q[parser])
          BANK_EMPTY, BANK_HAS_DATA: begin
            if (wr_take) begin
              cnt_q[parser] <= cnt_q[parser] + 1'b1;
            end
            if (overrun && i_desc.done) begin
              // Overrun on the final write
              state_q[parser] <= BANK_EMPTY;
              cnt_q[parser]   <= '0;
              drop_q          <= 1'b1;
            end else if (overrun) begin
              state_q[parser] <= BANK_OVERRUN;
            end else if (done_ok) begin
              state_q[parser] <= BANK_FIFO_OUT;
              // Idle drain bank, swap right away
              if (state_q[drain] == BANK_EMPTY) begin
                cur_q <= ~cur_q;
              end
            end else if (wr_take) begin
              state_q[parser] <= BANK_HAS_DATA;
            end
          end
          BANK_OVERRUN: begin
            // Writes discarded until the packet ends
            if (i_desc.done) begin
              state_q[parser] <= BANK_EMPTY;
              cnt_q[parser]   <= '0;
              drop_q          <= 1'b1;
            end
          end
          BANK_FIFO_OUT: begin
            // Waiting for the drain bank
            if (state_q[drain] == BANK_EMPTY) begin
              cur_q <= ~cur_q;
            end
          end
          BANK_ERROR: begin
            state_q[parser] <= BANK_EMPTY;
            cnt_q[parser]   <= '0;
          end
          default: begin
            state_q[parser] <= BANK_ERROR;
          end
        endcase
      end

      // Drain side
      if (mem_err[drain]) begin
        state_q[drain] <= BANK_ERROR;
      end else begin
        case (state_q[drain])
          BANK_EMPTY: begin
          end
          BANK_FIFO_OUT: begin
            if (i_packet_read) begin
              state_q[drain] <= BANK_EMPTY;
              cnt_q[drain]   <= '0;
            end
          end
          BANK_ERROR: begin
            state_q[drain] <= BANK_EMPTY;
            cnt_q[drain]   <= '0;
          end
          // Drain bank never fills
          default: begin
            state_q[drain] <= BANK_ERROR;
          end
        endcase
      end
    end
  end

  // Descriptor captured with the done
  always_ff @(posedge i_clk) begin
    if (done_ok) begin
      desc_q[parser] <= i_desc;
    end
  end

  // -------------------------------------------------------------------------
  // Outputs
  // -------------------------------------------------------------------------

  assign o_fifo_ready   = (state_q[drain] == BANK_FIFO_OUT);
  assign o_fifo_desc    = desc_q[drain];
  assign o_rd_data      = mem_rd[drain];
  assign o_parser_empty = (state_q[parser] == BANK_EMPTY);
  assign o_drop         = drop_q;

  // Full bank, overrun, finished bank waiting, or done with drain busy
  assign o_parser_full = ((state_q[parser] == BANK_HAS_DATA) && cnt_full) || !parser_open ||
                         (i_desc.done && (state_q[drain] != BANK_EMPTY));

  a_one_filling: assert property (@(posedge i_clk) disable iff (i_areset)
    !((state_q[0] == BANK_HAS_DATA) && (state_q[1] == BANK_HAS_DATA)));

  // Dispatcher only reads a bank handed over for output
  a_rd_in_fifo_out: assert property (@(posedge i_clk) disable iff (i_areset)
    i_rd_en |-> (state_q[drain] == BANK_FIFO_OUT));

endmodule

// ==== hdl/nts_tx_writer.sv ====
`timescale 1ns/1ps

module nts_tx_writer (
  input  logic                     i_clk,
  input  logic                     i_areset,
  input  logic                     i_parser_clear,
  input  logic                     i_parser_w_en,
  input  logic [63:0]              i_parser_w_data,
  input  logic                     i_parser_ipv4_done,
  input  logic                     i_parser_ipv6_done,
  input  logic [3:0]               i_parser_last_bytes,
  output nts_tx_pkg::nts_tx_wr_t   o_wr,
  output nts_tx_pkg::nts_tx_desc_t o_desc,
  output logic                     o_clear
);
  import nts_tx_pkg::*;

  logic         done;
  nts_tx_addr_t word_cnt_q;
  nts_tx_addr_t words_m1;
  nts_tx_len_t  len;
  logic         wr_en_q;
  logic [63:0]  wr_data_q;
  nts_tx_desc_t desc_q;
  logic         clear_q;

  assign done = i_parser_ipv4_done || i_parser_ipv6_done;

  // Words minus one, counting a write given with the done strobe
  assign words_m1 = word_cnt_q + nts_tx_addr_t'(i_parser_w_en) - 1'b1;
  // Full words plus valid bytes of the final word
  assign len = {words_m1, 3'b000} + nts_tx_len_t'(i_parser_last_bytes);

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      word_cnt_q <= '0;
      wr_en_q    <= 1'b0;
      desc_q     <= '0;
      clear_q    <= 1'b0;
    end else begin
      wr_en_q <= i_parser_w_en;
      clear_q <= i_parser_clear;
      // Clear cancels a done in the same cycle
      desc_q.done <= done && !i_parser_clear;
      if (done) begin
        desc_q.ipv6 <= i_parser_ipv6_done;
        desc_q.len  <= len;
      end
      // New packet count after done or clear
      if (i_parser_clear || done) begin
        word_cnt_q <= '0;
      end else if (i_parser_w_en) begin
        word_cnt_q <= word_cnt_q + 1'b1;
      end
    end
  end

  // Data word of the write record
  always_ff @(posedge i_clk) begin
    if (i_parser_w_en) begin
      wr_data_q <= i_parser_w_data;
    end
  end

  assign o_wr.w_en   = wr_en_q;
  assign o_wr.w_data = wr_data_q;
  assign o_desc      = desc_q;
  assign o_clear     = clear_q;

  // Parser reports one address family per packet
  a_one_done: assert property (@(posedge i_clk) disable iff (i_areset)
    !(i_parser_ipv4_done && i_parser_ipv6_done));

endmodule

// ==== hdl/nts_tx_mem.sv ====
`timescale 1ns/1ps

module nts_tx_mem (
  input  logic                     i_clk,
  input  logic                     i_areset,
  input  logic                     i_wr_en,
  input  nts_tx_pkg::nts_tx_addr_t i_wr_addr,
  input  logic [63:0]              i_wr_data,
  input  logic                     i_rd_en,
  input  nts_tx_pkg::nts_tx_addr_t i_rd_addr,
  output logic [63:0]              o_rd_data,
  output logic                     o_error
);
  import nts_tx_pkg::*;

  logic [63:0] mem [NTS_TX_WORDS];
  logic [63:0] rd_data_q;
  logic        error_q;
  logic        collide;

  // Same word written and read in one cycle
  assign collide = i_wr_en && i_rd_en && (i_wr_addr == i_rd_addr);

  // Word array, read data one cycle after enable
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
    if (i_rd_en) begin
      rd_data_q <= mem[i_rd_addr];
    end
  end

  // Error flag, one cycle pulse
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      error_q <= 1'b0;
    end else begin
      error_q <= collide;
    end
  end

  assign o_rd_data = rd_data_q;
  assign o_error   = error_q;

  // Ping-pong steering keeps reads and writes on different banks
  a_no_collide: assert property (@(posedge i_clk) disable iff (i_areset) !collide);

endmodule

// ==== hdl/nts_tx_pkg.sv ====
package nts_tx_pkg;

  // -------------------------------------------------------------------------
  // Bank sizing
  // -------------------------------------------------------------------------

  // Word address width of one bank, kept small so overrun is reachable
  localparam int NTS_TX_ADDR_WIDTH = 6;
  // Bank capacity in 64-bit words
  localparam int NTS_TX_WORDS      = 1 << NTS_TX_ADDR_WIDTH;
  // Byte length, eight bytes per word
  localparam int NTS_TX_LEN_WIDTH  = NTS_TX_ADDR_WIDTH + 3;

  typedef logic [NTS_TX_ADDR_WIDTH-1:0] nts_tx_addr_t;
  typedef logic [NTS_TX_LEN_WIDTH-1:0]  nts_tx_len_t;

  // -------------------------------------------------------------------------
  // Bank states
  // -------------------------------------------------------------------------

  typedef enum logic [2:0] {
    BANK_EMPTY    = 3'd0,
    BANK_HAS_DATA = 3'd1,
    BANK_FIFO_OUT = 3'd2,
    BANK_ERROR    = 3'd4,
    BANK_OVERRUN  = 3'd5
  } nts_tx_state_e;

  // Registered parser write
  typedef struct packed {
    logic        w_en;
    logic [63:0] w_data;
  } nts_tx_wr_t;

  // Packet descriptor, stored per bank
  // A packet filling the whole bank with 8 last bytes wraps len to zero
  typedef struct packed {
    logic        done;
    logic        ipv6;
    nts_tx_len_t len;
  } nts_tx_desc_t;

endpackage
